// File: hdl/player_pkg.sv
package player_pkg;

  // ==================================================
  // Widths with a meaning
  // ==================================================
  typedef logic [7:0]  sample_t;
  typedef logic [31:0] flash_word_t;
  typedef logic [22:0] word_addr_t;
  typedef logic [23:0] period_t;
  typedef logic [6:0]  seg_t;

  localparam int BYTES_PER_WORD = 4;

  // Digit 0 sits in the low bits
  typedef struct packed {
    seg_t digit5;
    seg_t digit4;
    seg_t digit3;
    seg_t digit2;
    seg_t digit1;
    seg_t digit0;
  } hex_segs_t;

  // ==================================================
  // Flash bus, read side only
  // ==================================================
  typedef struct packed {
    logic       read;
    word_addr_t address;
  } flash_req_t;

  typedef struct packed {
    logic        waitrequest;
    logic        readdatavalid;
    flash_word_t readdata;
  } flash_rsp_t;

  typedef enum logic [1:0] {rd_idle, rd_request, rd_wait_data} rd_state_t;

  typedef enum logic [1:0] {seq_fetch, seq_wait_word, seq_play} seq_state_t;

endpackage

// File: hdl/speed_control.sv
module speed_control #(
  parameter player_pkg::period_t DEFAULT_PERIOD = 24'd2272,
  parameter player_pkg::period_t MIN_PERIOD     = 24'd500,
  parameter player_pkg::period_t MAX_PERIOD     = 24'd20000,
  parameter player_pkg::period_t PERIOD_STEP    = 24'd100,
  parameter int unsigned         REPEAT_CYCLES  = 5_000_000
) (
  input  logic                CLK_50M,
  input  logic                reset,
  input  logic                key_faster,
  input  logic                key_slower,
  input  logic                key_default,
  output player_pkg::period_t period
);

  localparam int CNT_W = (REPEAT_CYCLES > 1) ? $clog2(REPEAT_CYCLES) : 1;

  // Past these the next step would cross a limit
  localparam player_pkg::period_t FAST_LIMIT = MIN_PERIOD + PERIOD_STEP;
  localparam player_pkg::period_t SLOW_LIMIT = MAX_PERIOD - PERIOD_STEP;

  logic [CNT_W-1:0]    repeat_cnt;
  logic                repeat_wrap;
  player_pkg::period_t period_faster;
  player_pkg::period_t period_slower;

  assign repeat_wrap = (repeat_cnt == CNT_W'(REPEAT_CYCLES - 1));

  assign period_faster = (period <= FAST_LIMIT) ? MIN_PERIOD : period - PERIOD_STEP;
  assign period_slower = (period >= SLOW_LIMIT) ? MAX_PERIOD : period + PERIOD_STEP;

  // Auto-repeat rate limit, keys only count in a wrap cycle
  always_ff @(posedge CLK_50M)
  begin
    if (reset)
      repeat_cnt <= '0;
    else if (repeat_wrap)
      repeat_cnt <= '0;
    else
      repeat_cnt <= repeat_cnt + 1'b1;
  end

  // Default key wins over faster, faster over slower
  always_ff @(posedge CLK_50M)
  begin
    if (reset)
      period <= DEFAULT_PERIOD;
    else if (repeat_wrap)
    begin
      if (key_default)
        period <= DEFAULT_PERIOD;
      else if (key_faster)
        period <= period_faster;
      else if (key_slower)
        period <= period_slower;
    end
  end

endmodule

// File: hdl/sample_tick_gen.sv
module sample_tick_gen (
  input  logic                CLK_50M,
  input  logic                reset,
  input  player_pkg::period_t period,
  output logic                tick
);

  player_pkg::period_t count;

  // Reload at every tick, so spacing is one full period
  always_ff @(posedge CLK_50M)
  begin
    if (reset)
    begin
      count <= period;
      tick  <= 1'b0;
    end
    else if (count <= player_pkg::period_t'(1))
    begin
      count <= period;
      tick  <= 1'b1;
    end
    else
    begin
      count <= count - 1'b1;
      tick  <= 1'b0;
    end
  end

endmodule

// File: hdl/flash_read_master.sv
module flash_read_master (
  input  logic                    CLK_50M,
  input  logic                    reset,
  input  logic                    fetch_start,
  input  player_pkg::word_addr_t  fetch_addr,
  output logic                    fetch_done,
  output player_pkg::flash_word_t fetch_data,
  output player_pkg::flash_req_t  flash_req,
  input  player_pkg::flash_rsp_t  flash_rsp
);

  player_pkg::rd_state_t  state;
  player_pkg::word_addr_t addr_q;

  // Read is high exactly while the request waits to be accepted
  assign flash_req = '{read: (state == player_pkg::rd_request), address: addr_q};

  always_ff @(posedge CLK_50M)
  begin
    if (reset)
    begin
      state      <= player_pkg::rd_idle;
      fetch_done <= 1'b0;
    end
    else
    begin
      fetch_done <= 1'b0;
      unique case (state)
        player_pkg::rd_idle:
          if (fetch_start)
            state <= player_pkg::rd_request;
        // Address and read held while the slave stalls
        player_pkg::rd_request:
          if (!flash_rsp.waitrequest)
            state <= player_pkg::rd_wait_data;
        player_pkg::rd_wait_data:
          if (flash_rsp.readdatavalid)
          begin
            fetch_done <= 1'b1;
            state      <= player_pkg::rd_idle;
          end
        default:
          state <= player_pkg::rd_idle;
      endcase
    end
  end

  // Payload registers
  always_ff @(posedge CLK_50M)
  begin
    if (state == player_pkg::rd_idle && fetch_start)
      addr_q <= fetch_addr;
    if (state == player_pkg::rd_wait_data && flash_rsp.readdatavalid)
      fetch_data <= flash_rsp.readdata;
  end

endmodule

// File: hdl/sample_sequencer.sv
module sample_sequencer #(
  parameter player_pkg::word_addr_t LAST_WORD = 23'h7FFFF
) (
  input  logic                    CLK_50M,
  input  logic                    reset,
  input  logic                    tick,
  input  logic                    play,
  input  logic                    backward,
  input  logic                    restart,
  input  logic                    fetch_done,
  input  player_pkg::flash_word_t fetch_data,
  output logic                    fetch_start,
  output player_pkg::word_addr_t  fetch_addr,
  output player_pkg::sample_t     sample,
  output logic                    sample_strobe
);

  localparam int IDX_W = $clog2(player_pkg::BYTES_PER_WORD);
  localparam logic [IDX_W-1:0] LAST_IDX = IDX_W'(player_pkg::BYTES_PER_WORD - 1);

  player_pkg::seq_state_t  state;
  player_pkg::word_addr_t  word_addr;
  player_pkg::word_addr_t  next_addr;
  player_pkg::flash_word_t word_q;
  logic [IDX_W-1:0]        byte_idx;
  logic                    last_byte;
  logic                    stale;

  assign fetch_addr = word_addr;
  assign last_byte  = backward ? (byte_idx == '0) : (byte_idx == LAST_IDX);

  // Song range wraps at both ends
  always_comb
  begin
    if (backward)
      next_addr = (word_addr == '0) ? LAST_WORD : word_addr - 1'b1;
    else
      next_addr = (word_addr == LAST_WORD) ? '0 : word_addr + 1'b1;
  end

  always_ff @(posedge CLK_50M)
  begin
    if (reset)
    begin
      state         <= player_pkg::seq_fetch;
      word_addr     <= '0;
      byte_idx      <= '0;
      stale         <= 1'b0;
      fetch_start   <= 1'b0;
      sample_strobe <= 1'b0;
    end
    else
    begin
      fetch_start   <= 1'b0;
      sample_strobe <= 1'b0;
      unique case (state)
        player_pkg::seq_fetch:
        begin
          fetch_start <= 1'b1;
          state       <= player_pkg::seq_wait_word;
        end
        player_pkg::seq_wait_word:
          if (fetch_done)
            state <= stale ? player_pkg::seq_fetch : player_pkg::seq_play;
        player_pkg::seq_play:
          // Ticks with no word held are simply lost
          if (tick && play && !restart)
          begin
            sample_strobe <= 1'b1;
            byte_idx      <= backward ? byte_idx - 1'b1 : byte_idx + 1'b1;
            if (last_byte)
            begin
              word_addr <= next_addr;
              state     <= player_pkg::seq_fetch;
            end
          end
        default:
          state <= player_pkg::seq_fetch;
      endcase
      if (fetch_done)
        stale <= 1'b0;

      // A read already in flight must finish before the refetch
      if (restart)
      begin
        word_addr <= backward ? LAST_WORD : '0;
        byte_idx  <= backward ? LAST_IDX : '0;
        if (state == player_pkg::seq_play)
          state <= player_pkg::seq_fetch;
        else if (state == player_pkg::seq_wait_word && fetch_done)
          state <= player_pkg::seq_fetch;
        else if (state == player_pkg::seq_wait_word)
          stale <= 1'b1;
      end
    end
  end

  always_ff @(posedge CLK_50M)
  begin
    if (state == player_pkg::seq_wait_word && fetch_done)
      word_q <= fetch_data;
    if (state == player_pkg::seq_play && tick && play && !restart)
      sample <= word_q[8*byte_idx +: 8];
  end

endmodule

// File: hdl/hex_display.sv
module hex_display (
  input  logic                  CLK_50M,
  input  player_pkg::period_t   period,
  output player_pkg::hex_segs_t hex
);

  localparam int SEG_W   = $bits(player_pkg::seg_t);
  localparam int DIGITS  = $bits(player_pkg::period_t) / 4;

  // Active low, segment order gfedcba
  function automatic player_pkg::seg_t glyph(input logic [3:0] nibble);
    unique case (nibble)
      4'h0: glyph = 7'b1000000;
      4'h1: glyph = 7'b1111001;
      4'h2: glyph = 7'b0100100;
      4'h3: glyph = 7'b0110000;
      4'h4: glyph = 7'b0011001;
      4'h5: glyph = 7'b0010010;
      4'h6: glyph = 7'b0000010;
      4'h7: glyph = 7'b1111000;
      4'h8: glyph = 7'b0000000;
      4'h9: glyph = 7'b0010000;
      4'hA: glyph = 7'b0001000;
      4'hB: glyph = 7'b0000011;
      4'hC: glyph = 7'b1000110;
      4'hD: glyph = 7'b0100001;
      4'hE: glyph = 7'b0000110;
      default: glyph = 7'b0001110;
    endcase
  endfunction

  // One glyph per nibble, digit 0 from the low nibble
  always_ff @(posedge CLK_50M)
  begin
    for (int i = 0; i < DIGITS; i++)
    begin
      hex[SEG_W*i +: SEG_W] <= glyph(period[4*i +: 4]);
    end
  end

endmodule

// File: hdl/ipod_player.sv
module ipod_player #(
  parameter player_pkg::period_t    DEFAULT_PERIOD = 24'd2272,
  parameter player_pkg::period_t    MIN_PERIOD     = 24'd500,
  parameter player_pkg::period_t    MAX_PERIOD     = 24'd20000,
  parameter player_pkg::period_t    PERIOD_STEP    = 24'd100,
  parameter int unsigned            REPEAT_CYCLES  = 5_000_000,
  parameter player_pkg::word_addr_t LAST_WORD      = 23'h7FFFF
) (
  input  logic                   CLK_50M,
  input  logic                   reset,
  input  logic                   key_faster,
  input  logic                   key_slower,
  input  logic                   key_default,
  input  logic                   play,
  input  logic                   backward,
  input  logic                   restart,
  output player_pkg::flash_req_t flash_req,
  input  player_pkg::flash_rsp_t flash_rsp,
  output player_pkg::sample_t    sample,
  output logic                   sample_strobe,
  output player_pkg::period_t    sample_period,
  output player_pkg::hex_segs_t  hex
);

  logic                    tick;
  logic                    fetch_start;
  logic                    fetch_done;
  player_pkg::word_addr_t  fetch_addr;
  player_pkg::flash_word_t fetch_data;

  // ==================================================
  // Sample rate
  // ==================================================
  speed_control #(
    .DEFAULT_PERIOD (DEFAULT_PERIOD),
    .MIN_PERIOD     (MIN_PERIOD),
    .MAX_PERIOD     (MAX_PERIOD),
    .PERIOD_STEP    (PERIOD_STEP),
    .REPEAT_CYCLES  (REPEAT_CYCLES)
  ) u_speed_control (
    .CLK_50M     (CLK_50M),
    .reset       (reset),
    .key_faster  (key_faster),
    .key_slower  (key_slower),
    .key_default (key_default),
    .period      (sample_period)
  );

  sample_tick_gen u_sample_tick_gen (
    .CLK_50M (CLK_50M),
    .reset   (reset),
    .period  (sample_period),
    .tick    (tick)
  );

  hex_display u_hex_display (
    .CLK_50M (CLK_50M),
    .period  (sample_period),
    .hex     (hex)
  );

  // ==================================================
  // Flash playback path
  // ==================================================
  sample_sequencer #(
    .LAST_WORD (LAST_WORD)
  ) u_sample_sequencer (
    .CLK_50M       (CLK_50M),
    .reset         (reset),
    .tick          (tick),
    .play          (play),
    .backward      (backward),
    .restart       (restart),
    .fetch_done    (fetch_done),
    .fetch_data    (fetch_data),
    .fetch_start   (fetch_start),
    .fetch_addr    (fetch_addr),
    .sample        (sample),
    .sample_strobe (sample_strobe)
  );

  flash_read_master u_flash_read_master (
    .CLK_50M     (CLK_50M),
    .reset       (reset),
    .fetch_start (fetch_start),
    .fetch_addr  (fetch_addr),
    .fetch_done  (fetch_done),
    .fetch_data  (fetch_data),
    .flash_req   (flash_req),
    .flash_rsp   (flash_rsp)
  );

endmodule

// File: verif/player_checker.sv
module player_checker #(
  parameter player_pkg::period_t    DEFAULT_PERIOD = 24'd40,
  parameter player_pkg::period_t    MIN_PERIOD     = 24'd20,
  parameter player_pkg::period_t    MAX_PERIOD     = 24'd80,
  parameter player_pkg::period_t    PERIOD_STEP    = 24'd10,
  parameter player_pkg::word_addr_t LAST_WORD      = 23'd63
) (
  input logic                   CLK_50M,
  input logic                   reset,
  input logic                   play,
  input logic                   backward,
  input logic                   restart,
  input player_pkg::flash_req_t flash_req,
  input player_pkg::flash_rsp_t flash_rsp,
  input player_pkg::sample_t    sample,
  input logic                   sample_strobe,
  input player_pkg::period_t    sample_period,
  input player_pkg::hex_segs_t  hex
);
  timeunit 1ns;
  timeprecision 100ps;

  bit                  failed = 1'b0;
  logic                past_valid, outstanding, play_q, dir, expect_first, seen_strobe;
  player_pkg::sample_t prev, expected_sample;
  player_pkg::period_t period_q;
  int unsigned         gap_cnt, stable_cnt;

  // Active-high gfedcba glyphs, inverted for the active-low digits
  function automatic player_pkg::seg_t seg_of(input logic [3:0] n);
    logic [6:0] on [16] = '{7'h3F, 7'h06, 7'h5B, 7'h4F, 7'h66, 7'h6D, 7'h7D, 7'h07,
                            7'h7F, 7'h6F, 7'h77, 7'h7C, 7'h39, 7'h5E, 7'h79, 7'h71};
    return ~on[n];
  endfunction

  function automatic player_pkg::hex_segs_t hex_of(input player_pkg::period_t p);
    return '{digit5: seg_of(p[23:20]), digit4: seg_of(p[19:16]), digit3: seg_of(p[15:12]),
             digit2: seg_of(p[11:8]), digit1: seg_of(p[7:4]), digit0: seg_of(p[3:0])};
  endfunction

  // First byte after restart is the start of the range in that direction
  assign expected_sample = expect_first ? (dir ? 8'hFF : 8'h00) : (dir ? prev - 1'b1 : prev + 1'b1);

  always_ff @(posedge CLK_50M)
  begin
    play_q   <= play;
    period_q <= sample_period;
    if (reset)
    begin
      past_valid   <= 1'b0;
      outstanding  <= 1'b0;
      dir          <= 1'b0;
      expect_first <= 1'b1;
      seen_strobe  <= 1'b0;
      gap_cnt      <= 0;
      stable_cnt   <= 0;
    end
    else
    begin
      past_valid <= 1'b1;
      if (flash_rsp.readdatavalid)
        outstanding <= 1'b0;
      if (flash_req.read && !flash_rsp.waitrequest)
        outstanding <= 1'b1;
      stable_cnt <= (sample_period != period_q) ? 0 : stable_cnt + 1;
      gap_cnt    <= sample_strobe ? 1 : gap_cnt + 1;
      if (sample_strobe)
      begin
        prev         <= sample;
        expect_first <= 1'b0;
        seen_strobe  <= 1'b1;
      end
      if (restart)
      begin
        expect_first <= 1'b1;
        dir          <= backward;
      end
    end
  end

  // ==================================================
  // Flash bus
  // ==================================================
  a_bus_hold: assert property (@(posedge CLK_50M) disable iff (reset)
    flash_req.read && flash_rsp.waitrequest |=> flash_req.read && $stable(flash_req.address))
    else begin failed = 1'b1; $error("CHECK FAILED at %0t: flash_req.address expected %0d got %0d",
      $time, $past(flash_req.address), flash_req.address); end
  a_one_read: assert property (@(posedge CLK_50M) disable iff (reset)
    flash_req.read |-> !outstanding)
    else begin failed = 1'b1; $error("New flash read issued while a read was outstanding"); end
  a_addr_range: assert property (@(posedge CLK_50M) disable iff (reset)
    flash_req.read |-> flash_req.address <= LAST_WORD)
    else begin failed = 1'b1; $error("CHECK FAILED at %0t: flash_req.address expected <= %0d got %0d",
      $time, LAST_WORD, flash_req.address); end

  // ==================================================
  // Samples and tick spacing
  // ==================================================
  a_sample: assert property (@(posedge CLK_50M) disable iff (reset)
    sample_strobe |-> sample == expected_sample)
    else begin failed = 1'b1; $error("CHECK FAILED at %0t: sample expected %0d got %0d",
      $time, expected_sample, sample); end
  a_no_play: assert property (@(posedge CLK_50M) disable iff (reset)
    !play_q |-> !sample_strobe)
    else begin failed = 1'b1; $error("Sample strobe seen while play was low"); end
  a_gap_min: assert property (@(posedge CLK_50M) disable iff (reset)
    sample_strobe && seen_strobe |-> gap_cnt >= MIN_PERIOD)
    else begin failed = 1'b1; $error("CHECK FAILED at %0t: strobe gap expected >= %0d got %0d",
      $time, MIN_PERIOD, gap_cnt); end
  a_gap_multiple: assert property (@(posedge CLK_50M) disable iff (reset)
    sample_strobe && seen_strobe && stable_cnt >= gap_cnt + 4 |-> gap_cnt % sample_period == 0)
    else begin failed = 1'b1; $error("CHECK FAILED at %0t: strobe gap expected multiple of %0d got %0d",
      $time, sample_period, gap_cnt); end

  // ==================================================
  // Period and display
  // ==================================================
  a_period_reset: assert property (@(posedge CLK_50M) $past(reset) && !reset |->
    sample_period == DEFAULT_PERIOD)
    else begin failed = 1'b1; $error("CHECK FAILED at %0t: sample_period expected %0d got %0d",
      $time, DEFAULT_PERIOD, sample_period); end
  a_period_range: assert property (@(posedge CLK_50M) disable iff (reset)
    sample_period >= MIN_PERIOD && sample_period <= MAX_PERIOD)
    else begin failed = 1'b1; $error("sample_period %0d left the allowed range", sample_period); end
  a_period_step: assert property (@(posedge CLK_50M) disable iff (reset || !past_valid)
    sample_period != $past(sample_period) |-> sample_period == DEFAULT_PERIOD ||
    sample_period == $past(sample_period) + PERIOD_STEP ||
    sample_period == $past(sample_period) - PERIOD_STEP)
    else begin failed = 1'b1; $error("sample_period jumped from %0d to %0d",
      $past(sample_period), sample_period); end
  a_hex: assert property (@(posedge CLK_50M) disable iff (reset)
    past_valid |-> hex == hex_of($past(sample_period)))
    else begin failed = 1'b1; $error("CHECK FAILED at %0t: hex expected %h got %h",
      $time, hex_of($past(sample_period)), hex); end

endmodule

bind ipod_player player_checker #(
  .DEFAULT_PERIOD (DEFAULT_PERIOD),
  .MIN_PERIOD     (MIN_PERIOD),
  .MAX_PERIOD     (MAX_PERIOD),
  .PERIOD_STEP    (PERIOD_STEP),
  .LAST_WORD      (LAST_WORD)
) u_checker (
  .CLK_50M (CLK_50M), .reset (reset), .play (play), .backward (backward),
  .restart (restart), .flash_req (flash_req), .flash_rsp (flash_rsp), .sample (sample),
  .sample_strobe (sample_strobe), .sample_period (sample_period), .hex (hex)
);

// File: verif/tb_ipod_player.sv
module tb_ipod_player;
  timeunit 1ns;
  timeprecision 100ps;

  logic                   CLK_50M, reset, key_faster, key_slower, key_default;
  logic                   play, backward, restart;
  player_pkg::flash_req_t flash_req;
  player_pkg::flash_rsp_t flash_rsp;
  player_pkg::sample_t    sample;
  logic                   sample_strobe;
  player_pkg::period_t    sample_period;
  player_pkg::hex_segs_t  hex;

  int                     seed = 32'h2b6d;

  ipod_player #(
    .DEFAULT_PERIOD (24'd40),
    .MIN_PERIOD     (24'd20),
    .MAX_PERIOD     (24'd80),
    .PERIOD_STEP    (24'd10),
    .REPEAT_CYCLES  (8),
    .LAST_WORD      (23'd63)
  ) DUT (.*);

  initial
  begin
    CLK_50M = 1'b0;
    forever #10 CLK_50M = ~CLK_50M;
  end

  // Byte k of word A holds the byte address 4A+k
  function automatic player_pkg::flash_word_t word_at(input player_pkg::word_addr_t a);
    logic [7:0] base;
    base = 8'(a * 4);
    return {base + 8'd3, base + 8'd2, base + 8'd1, base};
  endfunction

  // ==================================================
  // Flash memory model
  // ==================================================
  initial
  begin
    int                     wait_left, lat_left;
    logic                   rd, wreq, rdv_next;
    player_pkg::word_addr_t addr, read_addr;
    flash_rsp = '0;
    wait_left = 0;
    lat_left  = 0;
    read_addr = '0;
    forever
    begin
      @(negedge CLK_50M);
      rd   = flash_req.read;
      addr = flash_req.address;
      wreq = flash_rsp.waitrequest;
      @(posedge CLK_50M);
      rdv_next = 1'b0;
      if (lat_left != 0)
      begin
        lat_left--;
        rdv_next = (lat_left == 0);
      end
      if (rd && !wreq)
      begin
        read_addr = addr;
        lat_left  = 1 + $unsigned($random(seed)) % 3;
        wait_left = $unsigned($random(seed)) % 4;
      end
      else if (rd && wait_left != 0)
        wait_left--;
      #1;
      flash_rsp.waitrequest   = (wait_left != 0);
      flash_rsp.readdatavalid = rdv_next;
      flash_rsp.readdata      = word_at(read_addr);
    end
  end

  // Any checker assertion ends the run
  always @(negedge CLK_50M)
  begin
    if (DUT.u_checker.failed)
    begin
      $display("*** FAILED ***");
      $fatal(1, "An assertion in the checker failed");
    end
  end

  task automatic count_strobes(input int n, input string what);
    int seen = 0;
    int cycles = 0;
    while (seen < n && cycles < n * 400)
    begin
      @(negedge CLK_50M);
      cycles++;
      if (sample_strobe)
        seen++;
    end
    if (seen < n)
    begin
      $display("*** FAILED ***");
      $fatal(1, "Too few sample strobes during %s", what);
    end
  endtask

  task automatic wait_period(input player_pkg::period_t value);
    int cycles = 0;
    while (sample_period != value && cycles < 2000)
    begin
      @(negedge CLK_50M);
      cycles++;
    end
    if (sample_period != value)
    begin
      $display("*** FAILED ***");
      $fatal(1, "sample_period never reached %0d", value);
    end
  endtask

  task automatic pulse_restart(input logic dir);
    @(posedge CLK_50M);
    #1 restart = 1'b1;
    backward = dir;
    @(posedge CLK_50M);
    #1 restart = 1'b0;
  endtask

  initial
  begin
    {key_faster, key_slower, key_default, play, backward, restart} = '0;
    reset = 1'b1;
    repeat (3) @(posedge CLK_50M);
    #1 reset = 1'b0;
    play = 1'b1;
    count_strobes(300, "forward playback");
    pulse_restart(1'b1);
    count_strobes(300, "backward playback");
    pulse_restart(1'b0);
    count_strobes(20, "playback after restart");
    @(posedge CLK_50M);
    #1 play = 1'b0;
    repeat (300) @(posedge CLK_50M);
    #1 play = 1'b1;
    count_strobes(10, "resumed playback");
    @(posedge CLK_50M);
    #1 key_faster = 1'b1;
    wait_period(24'd20);
    @(posedge CLK_50M);
    #1 key_faster = 1'b0;
    count_strobes(10, "fastest rate");
    @(posedge CLK_50M);
    #1 key_slower = 1'b1;
    wait_period(24'd80);
    @(posedge CLK_50M);
    #1 key_slower = 1'b0;
    count_strobes(10, "slowest rate");
    @(posedge CLK_50M);
    #1 key_default = 1'b1;
    wait_period(24'd40);
    @(posedge CLK_50M);
    #1 key_default = 1'b0;
    count_strobes(10, "default rate");
    @(negedge CLK_50M);
    if (DUT.u_checker.failed)
    begin
      $display("*** FAILED ***");
      $fatal(1, "An assertion in the checker failed");
    end
    else
    begin
      $display("*** PASSED ***");
      $finish;
    end
  end

endmodule

// File: tb.f
hdl/player_pkg.sv
hdl/speed_control.sv
hdl/sample_tick_gen.sv
hdl/flash_read_master.sv
hdl/sample_sequencer.sv
hdl/hex_display.sv
hdl/ipod_player.sv
verif/player_checker.sv
verif/tb_ipod_player.sv

// File: Makefile
VERILATOR ?= verilator
TOP       := tb_ipod_player
FILELIST  := tb.f
FLAGS     := --binary --timing --assert --timescale 1ns/100ps -Wno-fatal
OBJ_DIR   := obj_dir
SIM       := $(OBJ_DIR)/V$(TOP)
SOURCES   := $(shell grep -v '^+' $(FILELIST))

.PHONY: all run clean

all: $(SIM)

$(SIM): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(FLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: $(SIM)
	@out=$$(./$(SIM) 2>&1); echo "$$out"; echo "$$out" | grep -qF '*** PASSED ***'

clean:
	rm -rf $(OBJ_DIR)
